//--- Bender.yml
package:
  name: usb_transaction

sources:
  - include_dirs:
      - design
    files:
      - design/usb_pid_pkg.sv
      - design/usb_ep_pkg.sv
      - design/usb_token_decoder.sv
      - design/usb_endpoint_slice.sv
      - design/usb_tx_sequencer.sv
      - design/usb_transaction_top.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - sim/usb_transaction_sva.sv
      - sim/tb_usb_transaction.sv

//--- design/usb_endpoint_slice.sv
//----------------------------------------------------------------------
// one IN/OUT endpoint pair
//   data toggle of the IN side
//   answer to IN tokens and DATA packets for the sequencer
//   IN byte forwarding and registered OUT byte delivery
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module usb_endpoint_slice
    import usb_pid_pkg::*;
    import usb_ep_pkg::*;
#(
    parameter int EP_INDEX = 1,       // endpoint number, 1 .. 15
    parameter bit IN_ISO   = 1'b0,    // IN side isochronous
    parameter bit OUT_ISO  = 1'b0     // OUT side isochronous
) (
    input  wire         clk,
    input  wire         rstn,
    input  rx_event_t   ev,
    input  wire         grant,        // sequencer wants a byte
    input  ep_in_t      in_byte,
    output logic        in_ready,
    output ep_out_t     out_byte,
    output slice_resp_t resp
);

    localparam logic [3:0] EP_NUM = 4'(EP_INDEX);

    logic       sel;                  // this pair is the current endpoint
    logic       data1_q;              // next IN packet is DATA1
    logic       out_valid_q;
    logic [7:0] out_data_q;
    pid_t       in_pid;

    assign sel      = (ev.endp == EP_NUM);
    assign in_ready = sel & grant;    // byte moves with in_byte.valid

    //------------------------------------------------------------------
    // data toggle
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            data1_q <= 1'b0;
        else if (sel && ev.ack && !IN_ISO)
            data1_q <= ~data1_q;      // host took our packet
    end

    // NAK when the user has nothing, iso always DATA0
    always_comb begin
        if (!in_byte.valid)
            in_pid = PID_NAK;
        else if (data1_q && !IN_ISO)
            in_pid = PID_DATA1;
        else
            in_pid = PID_DATA0;
    end

    // zero when not selected, so the sequencer can OR all slices
    always_comb begin
        resp = '0;
        if (sel) begin
            resp.sel        = 1'b1;
            resp.pid        = in_pid;
            resp.has_data   = in_byte.valid;
            resp.no_ack     = OUT_ISO;
            resp.byte_val   = in_byte.data;
            resp.byte_valid = in_byte.valid;
        end
    end

    //------------------------------------------------------------------
    // OUT byte delivery
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            out_valid_q <= 1'b0;
        else
            out_valid_q <= sel & ev.out_byte;
    end

    always_ff @(posedge clk) begin
        if (sel && ev.out_byte)
            out_data_q <= ev.byte_val;
    end

    assign out_byte = '{data: out_data_q, valid: out_valid_q};

endmodule

`default_nettype wire

//--- design/usb_ep_pkg.sv
//----------------------------------------------------------------------
// endpoint side types
//   ep_in_t       user IN byte with its valid
//   ep_out_t      delivered OUT byte strobe
//   slice_resp_t  answer of one endpoint slice to the sequencer
//----------------------------------------------------------------------
`default_nettype none

package usb_ep_pkg;

    import usb_pid_pkg::*;

    //------------------------------------------------------------------
    // user byte ports
    //------------------------------------------------------------------

    // IN byte offered by the user, pulled on in_ready
    typedef struct packed {
        logic [7:0] data;                 // byte to send
        logic       valid;                // byte present
    } ep_in_t;

    // OUT byte handed to the user, single-cycle strobe
    typedef struct packed {
        logic [7:0] data;                 // received byte
        logic       valid;                // strobe, no back-pressure
    } ep_out_t;

    //------------------------------------------------------------------
    // slice answer, all zero when the slice is not selected
    //------------------------------------------------------------------
    typedef struct packed {
        logic       sel;                  // slice owns current endpoint
        pid_t       pid;                  // answer to an IN token
        logic       has_data;             // IN data packet follows
        logic       no_ack;               // OUT side is isochronous
        logic [7:0] byte_val;             // IN byte of the endpoint
        logic       byte_valid;           // IN byte present
    } slice_resp_t;

endpackage

`default_nettype wire

//--- design/usb_pid_pkg.sv
//----------------------------------------------------------------------
// packet level types
//   pid_t       packet identifier codes used by the device
//   rx_event_t  one-cycle event bundle from the token decoder
//----------------------------------------------------------------------
`default_nettype none

package usb_pid_pkg;

    // 4-bit packet identifiers, low nibble of the pid byte
    typedef enum logic [3:0] {
        PID_OUT   = 4'h1,                 // token, host to device
        PID_IN    = 4'h9,                 // token, device to host
        PID_SETUP = 4'hD,                 // token, control setup
        PID_SOF   = 4'h5,                 // start of frame
        PID_DATA0 = 4'h3,                 // data, toggle 0
        PID_DATA1 = 4'hB,                 // data, toggle 1
        PID_ACK   = 4'h2,                 // handshake, accepted
        PID_NAK   = 4'hA                  // handshake, nothing to send
    } pid_t;

    // registered events, valid for one cycle each
    typedef struct packed {
        logic       in_tok;               // IN token received
        logic       out_tok;              // OUT token received
        logic       ack;                  // ACK handshake received
        logic       data_rx;              // DATA0/DATA1 packet finished
        logic       out_byte;             // one OUT data byte in byte_val
        logic [3:0] endp;                 // current endpoint, held
        logic [7:0] byte_val;             // received data byte
    } rx_event_t;

endpackage

`default_nettype wire

//--- design/usb_settings.svh
//----------------------------------------------------------------------
// build-time settings of the usb transaction controller
//   endpoint pair count, IN packet length, byte count width
//   isochronous masks, bit k-1 marks endpoint k
//----------------------------------------------------------------------
`ifndef USB_SETTINGS_SVH
`define USB_SETTINGS_SVH

// number of IN/OUT endpoint pairs, numbered 1 .. USB_NUM_EP
`define USB_NUM_EP   4

// IN packet byte length for every data endpoint
`define USB_MAX_PKT  10'h20

// width of the IN byte counter
`define USB_CNT_W    10

// isochronous IN endpoints, always DATA0 and no toggle
`define USB_IN_ISO   4'b0001

// isochronous OUT endpoints, their DATA packets get no ACK
`define USB_OUT_ISO  4'b0001

`endif

//--- design/usb_token_decoder.sv
//----------------------------------------------------------------------
// token decoder
//   qualifies finished packets by rp_fin and rp_okay
//   keeps the current endpoint from IN, OUT and SETUP tokens
//   registers the rx events and the sot / sof pulses
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module usb_token_decoder
    import usb_pid_pkg::*;
(
    input  wire        clk,
    input  wire        rstn,
    // packet layer receive side
    input  pid_t       rp_pid,
    input  wire  [3:0] rp_endp,
    input  wire        rp_byte_en,
    input  wire  [7:0] rp_byte,
    input  wire        rp_fin,
    input  wire        rp_okay,
    // decoded events
    output rx_event_t  ev,
    output logic       sot,           // start of transfer
    output logic       sof            // start of frame
);

    logic pkt_ok;                     // packet finished without error
    logic is_in;
    logic is_out;
    logic is_setup;
    logic is_data;

    assign pkt_ok   = rp_fin & rp_okay;
    assign is_in    = (rp_pid == PID_IN);
    assign is_out   = (rp_pid == PID_OUT);
    assign is_setup = (rp_pid == PID_SETUP);
    assign is_data  = (rp_pid == PID_DATA0) || (rp_pid == PID_DATA1);

    //------------------------------------------------------------------
    // event register
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ev  <= '0;
            sot <= 1'b0;
            sof <= 1'b0;
        end else begin
            ev.in_tok   <= pkt_ok & is_in;
            ev.out_tok  <= pkt_ok & is_out;
            ev.ack      <= pkt_ok & (rp_pid == PID_ACK);
            ev.data_rx  <= pkt_ok & is_data;
            ev.out_byte <= rp_byte_en;                   // routed by held endp
            if (rp_byte_en)
                ev.byte_val <= rp_byte;
            if (pkt_ok && (is_in || is_out || is_setup))
                ev.endp <= rp_endp;                      // new current endpoint

            // control transfers start with SETUP, data ones with IN/OUT
            if (rp_endp == 4'd0)
                sot <= pkt_ok & is_setup;
            else
                sot <= pkt_ok & (is_in | is_out);
            sof <= pkt_ok & (rp_pid == PID_SOF);
        end
    end

endmodule

`default_nettype wire

//--- design/usb_transaction_top.sv
//----------------------------------------------------------------------
// usb full-speed device transaction controller, top level
//   token decoder
//   one endpoint slice per IN/OUT endpoint pair
//   transmit sequencer
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "usb_settings.svh"

module usb_transaction_top
    import usb_pid_pkg::*;
    import usb_ep_pkg::*;
(
    input  wire                       clk,
    input  wire                       rstn,
    // packet layer receive side
    input  pid_t                      rp_pid,
    input  wire  [3:0]                rp_endp,
    input  wire                       rp_byte_en,
    input  wire  [7:0]                rp_byte,
    input  wire                       rp_fin,
    input  wire                       rp_okay,
    // packet layer transmit side
    output logic                      tp_sta,
    output pid_t                      tp_pid,
    input  wire                       tp_byte_req,
    output logic [7:0]                tp_byte,
    output logic                      tp_fin_n,
    // transfer and frame markers
    output logic                      sot,
    output logic                      sof,
    // user endpoints, index k serves endpoint k+1
    input  ep_in_t  [`USB_NUM_EP-1:0] ep_in,
    output logic    [`USB_NUM_EP-1:0] ep_in_ready,
    output ep_out_t [`USB_NUM_EP-1:0] ep_out
);

    localparam logic [`USB_NUM_EP-1:0] IN_ISO_MASK  = `USB_IN_ISO;
    localparam logic [`USB_NUM_EP-1:0] OUT_ISO_MASK = `USB_OUT_ISO;

    rx_event_t                    ev;      // decoder events to all blocks
    logic                         grant;   // byte request with count left
    slice_resp_t [`USB_NUM_EP-1:0] resp;

    usb_token_decoder u_decoder (
        .clk        (clk),
        .rstn       (rstn),
        .rp_pid     (rp_pid),
        .rp_endp    (rp_endp),
        .rp_byte_en (rp_byte_en),
        .rp_byte    (rp_byte),
        .rp_fin     (rp_fin),
        .rp_okay    (rp_okay),
        .ev         (ev),
        .sot        (sot),
        .sof        (sof)
    );

    //------------------------------------------------------------------
    // endpoint pairs 1 .. USB_NUM_EP
    //------------------------------------------------------------------
    for (genvar k = 0; k < `USB_NUM_EP; k++) begin : g_ep
        usb_endpoint_slice #(
            .EP_INDEX (k + 1),
            .IN_ISO   (IN_ISO_MASK[k]),
            .OUT_ISO  (OUT_ISO_MASK[k])
        ) u_slice (
            .clk      (clk),
            .rstn     (rstn),
            .ev       (ev),
            .grant    (grant),
            .in_byte  (ep_in[k]),
            .in_ready (ep_in_ready[k]),
            .out_byte (ep_out[k]),
            .resp     (resp[k])
        );
    end

    usb_tx_sequencer u_sequencer (
        .clk         (clk),
        .rstn        (rstn),
        .ev          (ev),
        .resp        (resp),
        .tp_byte_req (tp_byte_req),
        .grant       (grant),
        .tp_sta      (tp_sta),
        .tp_pid      (tp_pid),
        .tp_byte     (tp_byte),
        .tp_fin_n    (tp_fin_n)
    );

endmodule

`default_nettype wire

//--- design/usb_tx_sequencer.sv
//----------------------------------------------------------------------
// transmit sequencer
//   merges the slice answers
//   starts DATA/NAK answers to IN tokens and ACK after DATA packets
//   counts the IN packet bytes and forwards them to the packet layer
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "usb_settings.svh"

module usb_tx_sequencer
    import usb_pid_pkg::*;
    import usb_ep_pkg::*;
(
    input  wire                          clk,
    input  wire                          rstn,
    input  rx_event_t                    ev,
    input  slice_resp_t [`USB_NUM_EP-1:0] resp,
    input  wire                          tp_byte_req,
    output logic                         grant,
    // packet layer transmit side
    output logic                         tp_sta,
    output pid_t                         tp_pid,
    output logic [7:0]                   tp_byte,
    output logic                         tp_fin_n
);

    localparam logic [`USB_CNT_W-1:0] PKT_LEN = `USB_MAX_PKT;

    slice_resp_t           resp_or;   // answer of the selected slice
    logic [`USB_CNT_W-1:0] cnt_q;     // IN bytes still to send
    logic                  byte_move;

    // only the selected slice is non-zero
    always_comb begin
        resp_or = '0;
        for (int k = 0; k < `USB_NUM_EP; k++)
            resp_or = slice_resp_t'(resp_or | resp[k]);
    end

    assign grant     = tp_byte_req && (cnt_q != '0);
    assign byte_move = grant && resp_or.byte_valid;   // in_ready and valid

    //------------------------------------------------------------------
    // packet start and byte count
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tp_sta   <= 1'b0;
            tp_pid   <= PID_NAK;
            tp_fin_n <= 1'b0;
            cnt_q    <= '0;
        end else begin
            tp_sta <= 1'b0;
            if (tp_byte_req)
                tp_fin_n <= byte_move;                // low ends or stalls
            if (byte_move)
                cnt_q <= cnt_q - 1'b1;

            if (ev.in_tok) begin
                tp_sta <= 1'b1;
                tp_pid <= resp_or.sel ? resp_or.pid : PID_NAK;   // ep0 and unknown
                cnt_q  <= resp_or.has_data ? PKT_LEN : '0;
            end else if (ev.out_tok) begin
                cnt_q <= '0;                          // drop an unfinished IN
            end else if (ev.data_rx && !resp_or.no_ack) begin
                tp_sta <= 1'b1;
                tp_pid <= PID_ACK;
            end
        end
    end

    // payload byte
    always_ff @(posedge clk) begin
        if (byte_move)
            tp_byte <= resp_or.byte_val;
    end

endmodule

`default_nettype wire

//--- sim/tb_usb_transaction.sv
//----------------------------------------------------------------------
// testbench of the usb transaction controller
//   40 ns clock, 8-cycle reset, xorshift random transactions
//   model of toggles, answer pids, IN byte stream and OUT routing
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "usb_settings.svh"

module tb_usb_transaction
    import usb_pid_pkg::*;
    import usb_ep_pkg::*;
;

    localparam int N       = `USB_NUM_EP;
    localparam int PKT     = `USB_MAX_PKT;
    localparam int NUM_TXN = 60;
    localparam int LIMIT   = NUM_TXN * (PKT * 8 + 64) + 200;   // worst case per txn
    localparam logic [N-1:0] IN_ISO  = `USB_IN_ISO;
    localparam logic [N-1:0] OUT_ISO = `USB_OUT_ISO;

    logic             clk;
    logic             rstn;
    pid_t             rp_pid;
    logic [3:0]       rp_endp;
    logic             rp_byte_en;
    logic [7:0]       rp_byte;
    logic             rp_fin;
    logic             rp_okay;
    logic             tp_sta;
    pid_t             tp_pid;
    logic             tp_byte_req;
    logic [7:0]       tp_byte;
    logic             tp_fin_n;
    logic             sot;
    logic             sof;
    ep_in_t  [N-1:0]  ep_in;
    logic    [N-1:0]  ep_in_ready;
    ep_out_t [N-1:0]  ep_out;

    logic [31:0] rnd;                     // xorshift state
    logic [N:1]  toggle;                  // model data toggle per endpoint
    logic [11:0] out_exp[$];              // {endpoint, byte} in delivery order
    logic [11:0] out_got;
    int          sot_cnt;
    int          sot_exp;
    int          sof_cnt;
    int          sof_exp;
    int          cycle;

    usb_transaction_top dut0 (.*);

    //------------------------------------------------------------------
    // clock, timeout, helpers
    //------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle = 0;
        while (cycle <= LIMIT) begin
            @(posedge clk);
            cycle++;
        end
        $display("run did not finish within %0d cycles", LIMIT);
        $display("Checks failed");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    // one finished packet on the receive side
    task automatic send_packet(input pid_t pid, input logic [3:0] endp, input bit okay);
        @(posedge clk);
        rp_byte_en <= 1'b0;
        rp_pid     <= pid;
        rp_endp    <= endp;
        rp_fin     <= 1'b1;
        rp_okay    <= okay;
        if (okay && (((pid == PID_IN || pid == PID_OUT) && endp != 0)
                     || (pid == PID_SETUP && endp == 0)))
            sot_exp++;
        if (okay && pid == PID_SOF)
            sof_exp++;
        @(posedge clk);
        rp_fin  <= 1'b0;
        rp_okay <= 1'b0;
    endtask

    task automatic wait_start(input pid_t exp);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!tp_sta && n < 8);
        assert (tp_sta) else begin
            $display("no packet start after the received packet");
            abort_run();
        end
        assert (tp_pid == exp) else begin
            $display("Mismatch tp_pid: got %h expected %h", tp_pid, exp);
            abort_run();
        end
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!tp_sta) else begin
                $display("packet start where none is due");
                abort_run();
            end
        end
    endtask

    //------------------------------------------------------------------
    // IN byte stream with random valid gaps
    //------------------------------------------------------------------
    task automatic stream_bytes(input int k);
        int         remaining;
        bit         first;
        bit         v;
        bit         prev_move;
        logic [7:0] d;
        logic [7:0] prev_data;
        remaining = PKT;
        first     = 1'b1;
        prev_move = 1'b0;
        prev_data = '0;
        forever begin
            @(posedge clk);
            rnd = xorshift32(rnd);
            v   = (rnd[1:0] != 2'b00);
            d   = rnd[15:8];
            tp_byte_req       <= 1'b1;
            ep_in[k-1].valid  <= v;
            ep_in[k-1].data   <= d;
            @(negedge clk);
            if (!first) begin
                assert (tp_fin_n == prev_move) else begin
                    $display("Mismatch tp_fin_n: got %h expected %h", tp_fin_n, prev_move);
                    abort_run();
                end
                if (prev_move)
                    assert (tp_byte == prev_data) else begin
                        $display("Mismatch tp_byte: got %h expected %h", tp_byte, prev_data);
                        abort_run();
                    end
            end
            first = 1'b0;
            assert (ep_in_ready[k-1] == (remaining != 0)) else begin
                $display("Mismatch ep_in_ready: got %h expected %h",
                         ep_in_ready[k-1], remaining != 0);
                abort_run();
            end
            if (remaining == 0)
                break;
            prev_move = v;
            prev_data = d;
            if (v)
                remaining--;
        end
        @(posedge clk);
        tp_byte_req      <= 1'b0;
        ep_in[k-1].valid <= 1'b0;
    endtask

    task automatic do_in(input int k);
        bit   has;
        pid_t exp;
        rnd = xorshift32(rnd);
        has = (k != 0) && (rnd[1:0] != 2'b00);
        if (k != 0) begin
            @(posedge clk);
            ep_in[k-1].valid <= has;
            ep_in[k-1].data  <= rnd[23:16];
        end
        if (!has)
            exp = PID_NAK;
        else if (IN_ISO[k-1] || !toggle[k])
            exp = PID_DATA0;
        else
            exp = PID_DATA1;
        send_packet(PID_IN, 4'(k), 1'b1);
        wait_start(exp);
        if (has) begin
            stream_bytes(k);
            rnd = xorshift32(rnd);
            if (rnd[0]) begin
                send_packet(PID_ACK, 4'(k), 1'b1);
                if (!IN_ISO[k-1])
                    toggle[k] = ~toggle[k];     // host took the packet
                expect_quiet(3);
            end
        end else if (k != 0) begin
            @(posedge clk);
            ep_in[k-1].valid <= 1'b0;
        end
    endtask

    task automatic do_out(input int k);
        int         n;
        logic [7:0] b;
        send_packet(PID_OUT, 4'(k), 1'b1);
        rnd = xorshift32(rnd);
        n   = 1 + rnd[2:0];
        for (int i = 0; i < n; i++) begin
            rnd = xorshift32(rnd);
            b   = rnd[15:8];
            @(posedge clk);
            if (rnd[0]) begin             // idle gap between bytes
                rp_byte_en <= 1'b0;
                @(posedge clk);
            end
            rp_pid     <= PID_DATA0;
            rp_byte_en <= 1'b1;
            rp_byte    <= b;
            if (k != 0)
                out_exp.push_back({4'(k), b});
        end
        rnd = xorshift32(rnd);
        send_packet(rnd[0] ? PID_DATA1 : PID_DATA0, 4'(k), 1'b1);
        if (k != 0 && OUT_ISO[k-1])
            expect_quiet(4);
        else
            wait_start(PID_ACK);
    endtask

    //------------------------------------------------------------------
    // monitors
    //------------------------------------------------------------------
    always @(negedge clk) begin
        if (rstn) begin
            if (sot)
                sot_cnt++;
            if (sof)
                sof_cnt++;
            for (int j = 0; j < N; j++) begin
                if (ep_out[j].valid) begin
                    assert (out_exp.size() != 0) else begin
                        $display("OUT byte on endpoint %0d with none outstanding", j + 1);
                        abort_run();
                    end
                    out_got = out_exp.pop_front();
                    assert (out_got == {4'(j + 1), ep_out[j].data}) else begin
                        $display("Mismatch ep_out: got %h expected %h",
                                 {4'(j + 1), ep_out[j].data}, out_got);
                        abort_run();
                    end
                end
            end
        end
    end

    //------------------------------------------------------------------
    // main sequence
    //------------------------------------------------------------------
    initial begin
        int sel;
        int k;
        rnd         = 32'hd57a_c4b3;
        toggle      = '0;
        sot_cnt     = 0;
        sot_exp     = 0;
        sof_cnt     = 0;
        sof_exp     = 0;
        rstn        = 1'b0;
        rp_pid      = PID_NAK;
        rp_endp     = '0;
        rp_byte_en  = 1'b0;
        rp_byte     = '0;
        rp_fin      = 1'b0;
        rp_okay     = 1'b0;
        tp_byte_req = 1'b0;
        ep_in       = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!tp_sta && !tp_fin_n && !sot && !sof && ep_in_ready == '0) else begin
                $display("outputs active after reset");
                abort_run();
            end
        end

        for (int t = 0; t < NUM_TXN; t++) begin
            rnd = xorshift32(rnd);
            sel = rnd[2:0];
            k   = rnd[15:8] % (N + 1);
            if (sel <= 2)
                do_in(k);
            else if (sel <= 5)
                do_out(k);
            else if (sel == 6) begin
                send_packet(PID_SOF, 4'd0, 1'b1);
                send_packet(PID_SETUP, 4'd0, 1'b1);
            end else begin
                send_packet(rnd[16] ? PID_IN : PID_SOF, 4'(1 + rnd[17]), 1'b0);
                expect_quiet(3);
            end
        end

        repeat (6) @(negedge clk);
        if (out_exp.size() == 0 && sot_cnt == sot_exp && sof_cnt == sof_exp) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Mismatch counts: sot %h/%h sof %h/%h open OUT bytes %h",
                     sot_cnt, sot_exp, sof_cnt, sof_exp, out_exp.size());
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- sim/usb_transaction_sva.sv
//----------------------------------------------------------------------
// protocol assertions for the transaction controller
//   quiet outputs after reset until the first good packet
//   single-cycle packet start, IN tokens answered two cycles later
//   sot / sof only after good packets, OUT strobe two cycles after byte
//   bind into usb_transaction_top
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "usb_settings.svh"

module usb_transaction_sva
    import usb_pid_pkg::*;
    import usb_ep_pkg::*;
(
    input wire                       clk,
    input wire                       rstn,
    input pid_t                      rp_pid,
    input wire                       rp_byte_en,
    input wire                       rp_fin,
    input wire                       rp_okay,
    input wire                       sot,
    input wire                       sof,
    input wire                       tp_sta,
    input wire                       tp_fin_n,
    input wire [`USB_NUM_EP-1:0]     ep_in_ready,
    input ep_out_t [`USB_NUM_EP-1:0] ep_out
);

    logic                   seen_pkt;     // a good packet has finished
    logic [`USB_NUM_EP-1:0] out_valid;    // OUT strobes of all pairs

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            seen_pkt <= 1'b0;
        else if (rp_fin && rp_okay)
            seen_pkt <= 1'b1;
    end

    always_comb begin
        for (int k = 0; k < `USB_NUM_EP; k++)
            out_valid[k] = ep_out[k].valid;
    end

    // nothing moves until the host has sent something
    a_quiet: assert property (@(posedge clk) disable iff (!rstn)
        !seen_pkt |-> !sot && !sof && !tp_sta && !tp_fin_n
                      && (ep_in_ready == '0) && (out_valid == '0))
        else $error("outputs active before the first packet");

    a_sta_pulse: assert property (@(posedge clk) disable iff (!rstn)
        tp_sta |=> !tp_sta)
        else $error("tp_sta longer than one cycle");

    // every good IN token gets DATA or NAK, decoder plus sequencer delay
    a_in_answer: assert property (@(posedge clk) disable iff (!rstn)
        (rp_fin && rp_okay && rp_pid == PID_IN) |-> ##2 tp_sta)
        else $error("IN token not answered two cycles later");

    a_marker_ok: assert property (@(posedge clk) disable iff (!rstn)
        (sot || sof) |-> $past(rp_fin && rp_okay))
        else $error("sot or sof without a good packet before it");

    a_out_delay: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid != '0) |-> $past(rp_byte_en, 2))
        else $error("OUT byte delivered without a received byte");

endmodule

bind usb_transaction_top usb_transaction_sva sva0 (
    .clk         (clk),
    .rstn        (rstn),
    .rp_pid      (rp_pid),
    .rp_byte_en  (rp_byte_en),
    .rp_fin      (rp_fin),
    .rp_okay     (rp_okay),
    .sot         (sot),
    .sof         (sof),
    .tp_sta      (tp_sta),
    .tp_fin_n    (tp_fin_n),
    .ep_in_ready (ep_in_ready),
    .ep_out      (ep_out)
);

`default_nettype wire

//--- usb_transaction_top.f
+incdir+design
design/usb_pid_pkg.sv
design/usb_ep_pkg.sv
design/usb_token_decoder.sv
design/usb_endpoint_slice.sv
design/usb_tx_sequencer.sv
design/usb_transaction_top.sv
sim/usb_transaction_sva.sv
sim/tb_usb_transaction.sv
